// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - files:
      - source/soc_pkg.sv
      - source/bus_arbiter.sv
      - source/bus_decoder.sv
      - source/sram_slave.sv
      - source/timer_slave.sv
      - source/irq_controller.sv
      - source/soc_bus_top.sv
  - target: simulation
    files:
      - tb/tb_clock.sv
      - tb/soc_bus_checker.sv
      - tb/soc_bus_tb.sv

// ==== sim.f ====
source/soc_pkg.sv
source/bus_arbiter.sv
source/bus_decoder.sv
source/sram_slave.sv
source/timer_slave.sv
source/irq_controller.sv
source/soc_bus_top.sv
tb/tb_clock.sv
tb/soc_bus_checker.sv
tb/soc_bus_tb.sv

// ==== source/bus_arbiter.sv ====
/*
 * bus arbiter
 * round-robin grant of the shared bus between the host and
 * debug masters, grant held until the access is acknowledged
 */

`timescale 1ns/1ps

module bus_arbiter (
	input  logic             clk,
	input  logic             reset,
	input  soc_pkg::bus_req_t host_req_i,
	input  soc_pkg::bus_req_t dbg_req_i,
	input  soc_pkg::bus_rsp_t bus_rsp_i,
	output soc_pkg::bus_req_t bus_req_o,
	output soc_pkg::bus_rsp_t host_rsp_o,
	output soc_pkg::bus_rsp_t dbg_rsp_o
);

	// owner encoding: 0 host, 1 debug
	logic busy;
	logic owner;
	logic last_owner;
	logic pick;

	// --------------------
	// grant selection
	// --------------------
	always_comb begin
		if (host_req_i.stb && dbg_req_i.stb) begin
			// both waiting, the one not served last wins
			pick = ~last_owner;
		end else begin
			pick = dbg_req_i.stb;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy       <= 1'b0;
			owner      <= 1'b0;
			// first grant goes to the host
			last_owner <= 1'b1;
		end else if (!busy) begin
			if (host_req_i.stb || dbg_req_i.stb) begin
				busy  <= 1'b1;
				owner <= pick;
			end
		end else if (bus_rsp_i.ack) begin
			busy       <= 1'b0;
			last_owner <= owner;
		end
	end

	// --------------------
	// forwarding
	// --------------------
	always_comb begin
		bus_req_o = '0;
		if (busy) begin
			bus_req_o = owner ? dbg_req_i : host_req_i;
		end
	end

	// response goes back to the owner only
	assign host_rsp_o.ack = busy & ~owner & bus_rsp_i.ack;
	assign host_rsp_o.dat = (busy && !owner) ? bus_rsp_i.dat : '0;
	assign dbg_rsp_o.ack  = busy & owner & bus_rsp_i.ack;
	assign dbg_rsp_o.dat  = (busy && owner) ? bus_rsp_i.dat : '0;

endmodule

// ==== source/bus_decoder.sv ====
/*
 * bus region decoder
 * steers the strobe to sram, timer or interrupt controller by
 * address region and muxes the response back
 */

`timescale 1ns/1ps

module bus_decoder (
	input  soc_pkg::bus_req_t bus_req_i,
	output soc_pkg::bus_rsp_t bus_rsp_o,
	output soc_pkg::bus_req_t sram_req_o,
	output soc_pkg::bus_req_t timer_req_o,
	output soc_pkg::bus_req_t irq_req_o,
	input  soc_pkg::bus_rsp_t sram_rsp_i,
	input  soc_pkg::bus_rsp_t timer_rsp_i,
	input  soc_pkg::bus_rsp_t irq_rsp_i
);

	always_comb begin
		// same request everywhere, strobe only where it belongs
		sram_req_o      = bus_req_i;
		timer_req_o     = bus_req_i;
		irq_req_o       = bus_req_i;
		sram_req_o.stb  = 1'b0;
		timer_req_o.stb = 1'b0;
		irq_req_o.stb   = 1'b0;
		bus_rsp_o       = '0;

		case (bus_req_i.adr.f.region)
			soc_pkg::REGION_SRAM: begin
				sram_req_o.stb = bus_req_i.stb;
				bus_rsp_o      = sram_rsp_i;
			end
			soc_pkg::REGION_TIMER: begin
				timer_req_o.stb = bus_req_i.stb;
				bus_rsp_o       = timer_rsp_i;
			end
			soc_pkg::REGION_IRQ: begin
				irq_req_o.stb = bus_req_i.stb;
				bus_rsp_o     = irq_rsp_i;
			end
			default: begin
				// unmapped: immediate ack, zero data, write dropped
				bus_rsp_o.dat = '0;
				bus_rsp_o.ack = bus_req_i.stb;
			end
		endcase
	end

endmodule

// ==== source/irq_controller.sv ====
/*
 * interrupt controller
 * pending and enable registers for the interrupt factors,
 * registered request when any enabled factor is pending
 */

`timescale 1ns/1ps

module irq_controller (
	input  logic                        clk,
	input  logic                        reset,
	input  soc_pkg::bus_req_t            req_i,
	input  logic [soc_pkg::IRQ_NUM-1:0] irq_i,
	output soc_pkg::bus_rsp_t            rsp_o,
	output logic                        irq_o
);

	logic [soc_pkg::IRQ_NUM-1:0] pending;
	logic [soc_pkg::IRQ_NUM-1:0] mask;
	logic [soc_pkg::IRQ_NUM-1:0] clr;
	logic [soc_pkg::DAT_W-1:0]   rd_dat;
	logic                        ack_q;
	logic                        access;
	logic                        wr_pend;
	logic                        wr_ena;

	assign access  = req_i.stb & ~ack_q;
	assign wr_pend = access & req_i.we & (req_i.adr.f.index == soc_pkg::IRQ_PEND);
	assign wr_ena  = access & req_i.we & (req_i.adr.f.index == soc_pkg::IRQ_ENA);

	// write-1-clear, a live input wins over the clear
	assign clr = wr_pend ? req_i.dat[soc_pkg::IRQ_NUM-1:0] : '0;

	// --------------------
	// pending and mask
	// --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pending <= '0;
			mask    <= '0;
			irq_o   <= 1'b0;
			ack_q   <= 1'b0;
		end else begin
			pending <= (pending & ~clr) | irq_i;
			irq_o   <= |(pending & mask);
			ack_q   <= access;
			if (wr_ena) begin
				mask <= req_i.dat[soc_pkg::IRQ_NUM-1:0];
			end
		end
	end

	// --------------------
	// read back
	// --------------------
	always_ff @(posedge clk) begin
		if (access) begin
			rd_dat <= '0;
			if (req_i.adr.f.index == soc_pkg::IRQ_PEND) begin
				rd_dat[soc_pkg::IRQ_NUM-1:0] <= pending;
			end else if (req_i.adr.f.index == soc_pkg::IRQ_ENA) begin
				rd_dat[soc_pkg::IRQ_NUM-1:0] <= mask;
			end
		end
	end

	assign rsp_o.dat = rd_dat;
	assign rsp_o.ack = ack_q;

endmodule

// ==== source/soc_bus_top.sv ====
/*
 * soc bus subsystem top
 * two masters share one strobe/ack bus through the arbiter,
 * decoded to sram, timer and interrupt controller
 */

`timescale 1ns/1ps

module soc_bus_top (
	input  logic             clk,
	input  logic             reset,
	input  soc_pkg::bus_req_t host_req_i,
	output soc_pkg::bus_rsp_t host_rsp_o,
	input  soc_pkg::bus_req_t dbg_req_i,
	output soc_pkg::bus_rsp_t dbg_rsp_o,
	input  logic [1:0]       ext_irq_i,
	output logic             irq_o
);

	// --------------------
	// shared bus
	// --------------------
	soc_pkg::bus_req_t bus_req;
	soc_pkg::bus_rsp_t bus_rsp;

	bus_arbiter u_arbiter (
		.clk        (clk),
		.reset      (reset),
		.host_req_i (host_req_i),
		.dbg_req_i  (dbg_req_i),
		.bus_rsp_i  (bus_rsp),
		.bus_req_o  (bus_req),
		.host_rsp_o (host_rsp_o),
		.dbg_rsp_o  (dbg_rsp_o)
	);

	// --------------------
	// decoder and slaves
	// --------------------
	soc_pkg::bus_req_t sram_req;
	soc_pkg::bus_rsp_t sram_rsp;
	soc_pkg::bus_req_t timer_req;
	soc_pkg::bus_rsp_t timer_rsp;
	soc_pkg::bus_req_t irq_req;
	soc_pkg::bus_rsp_t irq_rsp;

	bus_decoder u_decoder (
		.bus_req_i   (bus_req),
		.bus_rsp_o   (bus_rsp),
		.sram_req_o  (sram_req),
		.timer_req_o (timer_req),
		.irq_req_o   (irq_req),
		.sram_rsp_i  (sram_rsp),
		.timer_rsp_i (timer_rsp),
		.irq_rsp_i   (irq_rsp)
	);

	sram_slave u_sram (
		.clk   (clk),
		.reset (reset),
		.req_i (sram_req),
		.rsp_o (sram_rsp)
	);

	logic timer_event;

	timer_slave u_timer (
		.clk     (clk),
		.reset   (reset),
		.req_i   (timer_req),
		.rsp_o   (timer_rsp),
		.event_o (timer_event)
	);

	// factor 0 timer, factors 1..2 external lines
	logic [soc_pkg::IRQ_NUM-1:0] irq_factor;
	assign irq_factor = {ext_irq_i, timer_event};

	irq_controller u_irq (
		.clk   (clk),
		.reset (reset),
		.req_i (irq_req),
		.irq_i (irq_factor),
		.rsp_o (irq_rsp),
		.irq_o (irq_o)
	);

endmodule

// ==== source/soc_pkg.sv ====
/*
 * soc bus package
 * address map, register indices, bus request and response
 * structs, and the word address union shared by the bus blocks
 */

package soc_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int DAT_W    = 32;
	localparam int SEL_W    = DAT_W / 8;
	localparam int ADR_W    = 30;
	localparam int REGION_W = 8;
	localparam int INDEX_W  = ADR_W - REGION_W;

	// --------------------
	// address map
	// --------------------
	// region is byte address bits 31..24
	localparam logic [REGION_W-1:0] REGION_SRAM  = 8'h01;
	localparam logic [REGION_W-1:0] REGION_IRQ   = 8'hf0;
	localparam logic [REGION_W-1:0] REGION_TIMER = 8'hf1;

	// internal sram
	localparam int SRAM_WORDS = 256;
	localparam int SRAM_AW    = $clog2(SRAM_WORDS);

	// timer register indices
	localparam logic [INDEX_W-1:0] TIMER_CTL = 'd0;
	localparam logic [INDEX_W-1:0] TIMER_CMP = 'd1;
	localparam logic [INDEX_W-1:0] TIMER_CNT = 'd2;

	// interrupt controller
	// factor 0 is the timer, 1 and 2 the external lines
	localparam int IRQ_NUM = 3;
	localparam logic [INDEX_W-1:0] IRQ_PEND = 'd0;
	localparam logic [INDEX_W-1:0] IRQ_ENA  = 'd1;

	// --------------------
	// bus types
	// --------------------
	typedef struct packed {
		logic [REGION_W-1:0] region;
		logic [INDEX_W-1:0]  index;
	} bus_addr_fields_t;

	// decoder reads the region, slaves read the index
	typedef union packed {
		logic [ADR_W-1:0] word;
		bus_addr_fields_t f;
	} bus_addr_u;

	typedef struct packed {
		bus_addr_u        adr;
		logic [DAT_W-1:0] dat;
		logic             we;
		logic [SEL_W-1:0] sel;
		logic             stb;
	} bus_req_t;

	typedef struct packed {
		logic [DAT_W-1:0] dat;
		logic             ack;
	} bus_rsp_t;

endpackage

// ==== source/sram_slave.sv ====
/*
 * internal sram slave
 * byte-writable word memory with a one-cycle registered ack
 */

`timescale 1ns/1ps

module sram_slave (
	input  logic             clk,
	input  logic             reset,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::bus_rsp_t rsp_o
);

	logic [soc_pkg::DAT_W-1:0]   mem [soc_pkg::SRAM_WORDS];
	logic [soc_pkg::SRAM_AW-1:0] idx;
	logic [soc_pkg::DAT_W-1:0]   rd_dat;
	logic                        ack_q;
	logic                        access;

	assign idx    = req_i.adr.f.index[soc_pkg::SRAM_AW-1:0];
	assign access = req_i.stb & ~ack_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// byte lanes written under sel, whole word read
	always_ff @(posedge clk) begin
		if (access && req_i.we) begin
			for (int b = 0; b < soc_pkg::SEL_W; b++) begin
				if (req_i.sel[b]) begin
					mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
				end
			end
		end
		if (access) begin
			rd_dat <= mem[idx];
		end
	end

	assign rsp_o.dat = rd_dat;
	assign rsp_o.ack = ack_q;

endmodule

// ==== source/timer_slave.sv ====
/*
 * interval timer slave
 * counter runs to the compare value, wraps to zero and pulses
 * an event for one cycle
 */

`timescale 1ns/1ps

module timer_slave (
	input  logic             clk,
	input  logic             reset,
	input  soc_pkg::bus_req_t req_i,
	output soc_pkg::bus_rsp_t rsp_o,
	output logic             event_o
);

	logic                      enable;
	logic [soc_pkg::DAT_W-1:0] compare;
	logic [soc_pkg::DAT_W-1:0] counter;
	logic [soc_pkg::DAT_W-1:0] rd_dat;
	logic                      ack_q;
	logic                      access;
	logic                      wr_ctl;
	logic                      wr_cmp;

	assign access = req_i.stb & ~ack_q;
	assign wr_ctl = access & req_i.we & (req_i.adr.f.index == soc_pkg::TIMER_CTL);
	assign wr_cmp = access & req_i.we & (req_i.adr.f.index == soc_pkg::TIMER_CMP);

	// --------------------
	// registers
	// --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			enable  <= 1'b0;
			compare <= '0;
			counter <= '0;
			event_o <= 1'b0;
		end else begin
			event_o <= 1'b0;
			if (wr_ctl) begin
				// control write restarts the count
				enable  <= req_i.dat[0];
				counter <= '0;
			end else if (enable) begin
				if (counter == compare) begin
					counter <= '0;
					event_o <= 1'b1;
				end else begin
					counter <= counter + 1'b1;
				end
			end
			if (wr_cmp) begin
				compare <= req_i.dat;
			end
		end
	end

	// --------------------
	// bus response
	// --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			case (req_i.adr.f.index)
				soc_pkg::TIMER_CTL: rd_dat <= {{(soc_pkg::DAT_W-1){1'b0}}, enable};
				soc_pkg::TIMER_CMP: rd_dat <= compare;
				soc_pkg::TIMER_CNT: rd_dat <= counter;
				default:            rd_dat <= '0;
			endcase
		end
	end

	assign rsp_o.dat = rd_dat;
	assign rsp_o.ack = ack_q;

endmodule

// ==== tb/soc_bus_checker.sv ====
/*
 * bus protocol checker
 * bound into the arbiter, watches ack exclusivity, request
 * stability, single-cycle ack and the interrupt output in reset
 */

`timescale 1ns/1ps

module soc_bus_checker (
	input logic              clk,
	input logic              reset,
	input soc_pkg::bus_req_t host_req_i,
	input soc_pkg::bus_req_t dbg_req_i,
	input soc_pkg::bus_rsp_t host_rsp_i,
	input soc_pkg::bus_rsp_t dbg_rsp_i,
	input logic              irq_i
);

	// failed assertions so far
	int fails;

	// only the owner ever sees ack
	a_one_ack: assert property (@(posedge clk) disable iff (reset)
		!(host_rsp_i.ack && dbg_rsp_i.ack))
		else begin
			$error("ack returned to both masters in one cycle");
			fails++;
		end

	// --------------------
	// master handshake
	// --------------------
	a_host_stable: assert property (@(posedge clk) disable iff (reset)
		(host_req_i.stb && !host_rsp_i.ack) |=> $stable(host_req_i))
		else begin
			$error("host request changed before ack");
			fails++;
		end

	a_dbg_stable: assert property (@(posedge clk) disable iff (reset)
		(dbg_req_i.stb && !dbg_rsp_i.ack) |=> $stable(dbg_req_i))
		else begin
			$error("debug request changed before ack");
			fails++;
		end

	a_host_pulse: assert property (@(posedge clk) disable iff (reset)
		host_rsp_i.ack |=> !host_rsp_i.ack)
		else begin
			$error("host ack held longer than one cycle");
			fails++;
		end

	a_dbg_pulse: assert property (@(posedge clk) disable iff (reset)
		dbg_rsp_i.ack |=> !dbg_rsp_i.ack)
		else begin
			$error("debug ack held longer than one cycle");
			fails++;
		end

	a_irq_reset: assert property (@(posedge clk)
		reset |-> !irq_i)
		else begin
			$error("interrupt request high during reset");
			fails++;
		end

endmodule

// ==== tb/soc_bus_tb.sv ====
/*
 * soc bus subsystem testbench
 * drives both master ports through sram, unmapped, timer and
 * interrupt accesses and compares against a reference model
 */

`timescale 1ns/1ps

module soc_bus_tb;

	localparam int ACK_TIMEOUT = 20;
	localparam int IRQ_TIMEOUT = 50;
	localparam int POLL_LIMIT  = 40;
	localparam logic [soc_pkg::REGION_W-1:0] REGION_NONE = 8'h20;

	logic              clk;
	logic              reset;
	soc_pkg::bus_req_t host_req;
	soc_pkg::bus_req_t dbg_req;
	soc_pkg::bus_rsp_t host_rsp;
	soc_pkg::bus_rsp_t dbg_rsp;
	logic [1:0]        ext_irq;
	logic              irq;

	// reference state
	logic [31:0] ref_mem [soc_pkg::SRAM_WORDS];
	logic [2:0]  ref_pend;
	logic [2:0]  ref_mask;
	logic [31:0] ref_cmp;
	logic        ref_ena;
	bit          last_grant;
	bit          ack_order [$];

	// results waiting for the compare process
	string       name_q [$];
	logic [31:0] exp_q [$];
	logic [31:0] act_q [$];
	int          checks;
	int          errors;
	int          tests;
	int          err_mark;

	tb_clock u_clock (
		.clk_o   (clk),
		.reset_o (reset)
	);

	soc_bus_top DUT (
		.clk        (clk),
		.reset      (reset),
		.host_req_i (host_req),
		.host_rsp_o (host_rsp),
		.dbg_req_i  (dbg_req),
		.dbg_rsp_o  (dbg_rsp),
		.ext_irq_i  (ext_irq),
		.irq_o      (irq)
	);

	bind bus_arbiter soc_bus_checker u_checker (
		.clk        (clk),
		.reset      (reset),
		.host_req_i (host_req_i),
		.dbg_req_i  (dbg_req_i),
		.host_rsp_i (host_rsp_o),
		.dbg_rsp_i  (dbg_rsp_o),
		.irq_i      (soc_bus_top.irq_o)
	);

	// --------------------
	// reference model
	// --------------------
	function automatic logic [31:0] expected_read(input logic [7:0] region,
			input logic [soc_pkg::INDEX_W-1:0] index);
		logic [31:0] val;
		val = '0;
		case (region)
			soc_pkg::REGION_SRAM: val = ref_mem[index[soc_pkg::SRAM_AW-1:0]];
			soc_pkg::REGION_IRQ: begin
				if (index == soc_pkg::IRQ_PEND) val[2:0] = ref_pend;
				else if (index == soc_pkg::IRQ_ENA) val[2:0] = ref_mask;
			end
			soc_pkg::REGION_TIMER: begin
				// counter has no exact value so only its bound is checked
				if (index == soc_pkg::TIMER_CTL) val[0] = ref_ena;
				else if (index == soc_pkg::TIMER_CMP) val = ref_cmp;
			end
			default: val = '0;
		endcase
		return val;
	endfunction

	function automatic void model_write(input logic [7:0] region,
			input logic [soc_pkg::INDEX_W-1:0] index, input logic [3:0] sel,
			input logic [31:0] dat);
		case (region)
			soc_pkg::REGION_SRAM: begin
				for (int b = 0; b < 4; b++) begin
					if (sel[b]) ref_mem[index[soc_pkg::SRAM_AW-1:0]][8*b +: 8] = dat[8*b +: 8];
				end
			end
			soc_pkg::REGION_IRQ: begin
				if (index == soc_pkg::IRQ_PEND) ref_pend = ref_pend & ~dat[2:0];
				else if (index == soc_pkg::IRQ_ENA) ref_mask = dat[2:0];
			end
			soc_pkg::REGION_TIMER: begin
				if (index == soc_pkg::TIMER_CTL) ref_ena = dat[0];
				else if (index == soc_pkg::TIMER_CMP) ref_cmp = dat;
			end
			default: ;
		endcase
	endfunction

	// --------------------
	// checking
	// --------------------
	task automatic compare_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	function automatic void queue_check(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endfunction

	always @(negedge clk) begin
		while (name_q.size() > 0) begin
			compare_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
		end
	end

	task automatic report_test(input string name);
		// two edges let the compare process drain the queue
		repeat (2) @(posedge clk);
		tests++;
		$display("test %s: %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	// --------------------
	// bus and interrupt helpers
	// --------------------
	// lat counts edges from the first one that samples stb to the one that sees ack
	task automatic bus_access(input bit port, input logic [7:0] region,
			input logic [soc_pkg::INDEX_W-1:0] index, input bit we, input logic [3:0] sel,
			input logic [31:0] wdat, output logic [31:0] rdat, output int lat);
		soc_pkg::bus_req_t req;
		int edges;
		bit done;
		req              = '0;
		req.adr.f.region = region;
		req.adr.f.index  = index;
		req.dat          = wdat;
		req.we           = we;
		req.sel          = sel;
		req.stb          = 1'b1;
		edges            = 0;
		done             = 1'b0;
		rdat             = '0;
		@(posedge clk);
		if (port) dbg_req <= req;
		else host_req <= req;
		while (!done && edges < ACK_TIMEOUT) begin
			@(posedge clk);
			edges++;
			if (port ? dbg_rsp.ack : host_rsp.ack) begin
				rdat = port ? dbg_rsp.dat : host_rsp.dat;
				done = 1'b1;
			end
		end
		if (port) dbg_req.stb <= 1'b0;
		else host_req.stb <= 1'b0;
		lat = edges - 1;
		if (done) begin
			ack_order.push_back(port);
			last_grant = port;
			if (we) model_write(region, index, sel, wdat);
		end else begin
			errors++;
			$display("timeout: %s access to region %h index %0d never completed",
				port ? "debug" : "host", region, index);
		end
	endtask

	task automatic wait_irq_level(input logic level, input string what);
		int edges;
		edges = 0;
		while (irq !== level && edges < IRQ_TIMEOUT) begin
			@(posedge clk);
			edges++;
		end
		if (irq !== level) begin
			errors++;
			$display("timeout: %s", what);
		end
	endtask

	// --------------------
	// stimulus
	// --------------------
	initial begin
		logic [31:0] rdat;
		logic [31:0] rdat_h;
		logic [31:0] rdat_d;
		int          lat;
		int          lat_h;
		int          lat_d;
		logic [7:0]  idx [8];
		logic [31:0] cmp;
		int          polls;
		bit          seen;
		bit          exp_first;
		int          assert_fails;

		host_req   = '0;
		dbg_req    = '0;
		ext_irq    = '0;
		ref_pend   = '0;
		ref_mask   = '0;
		ref_cmp    = '0;
		ref_ena    = 1'b0;
		last_grant = 1'b1;
		void'($urandom(74));

		polls = 0;
		while (reset !== 1'b0 && polls < 100) begin
			@(posedge clk);
			polls++;
		end
		if (reset !== 1'b0) begin
			errors++;
			$display("reset was never released");
		end
		err_mark = errors;

		// full words first so partial writes land on known data
		for (int i = 0; i < 8; i++) begin
			idx[i] = $urandom_range(0, 127);
			bus_access(0, soc_pkg::REGION_SRAM, idx[i], 1, 4'hf, $urandom, rdat, lat);
		end
		for (int i = 0; i < 8; i++) begin
			bus_access(0, soc_pkg::REGION_SRAM, idx[i], 1, $urandom_range(1, 15),
				$urandom, rdat, lat);
		end
		for (int i = 0; i < 8; i++) begin
			bus_access(0, soc_pkg::REGION_SRAM, idx[i], 0, 4'hf, '0, rdat, lat);
			queue_check("sram read back", expected_read(soc_pkg::REGION_SRAM, idx[i]), rdat);
			queue_check("sram latency", 2, lat);
		end
		report_test("host sram");

		// host at 0x80.. and debug at 0xc0.. strobe on the same edge
		for (int i = 0; i < 4; i++) begin
			exp_first = ~last_grant;
			ack_order.delete();
			fork
				bus_access(0, soc_pkg::REGION_SRAM, 8'h80 + i, 1, 4'hf, $urandom, rdat_h, lat_h);
				bus_access(1, soc_pkg::REGION_SRAM, 8'hc0 + i, 1, 4'hf, $urandom, rdat_d, lat_d);
			join
			queue_check("write grant order", exp_first,
				ack_order.size() > 0 ? ack_order[0] : 1'bx);
			exp_first = ~last_grant;
			ack_order.delete();
			fork
				bus_access(0, soc_pkg::REGION_SRAM, 8'h80 + i, 0, 4'hf, '0, rdat_h, lat_h);
				bus_access(1, soc_pkg::REGION_SRAM, 8'hc0 + i, 0, 4'hf, '0, rdat_d, lat_d);
			join
			queue_check("read grant order", exp_first,
				ack_order.size() > 0 ? ack_order[0] : 1'bx);
			queue_check("host read", expected_read(soc_pkg::REGION_SRAM, 8'h80 + i), rdat_h);
			queue_check("debug read", expected_read(soc_pkg::REGION_SRAM, 8'hc0 + i), rdat_d);
		end
		report_test("contention");

		bus_access(0, REGION_NONE, 5, 0, 4'hf, '0, rdat, lat);
		queue_check("unmapped host read", expected_read(REGION_NONE, 5), rdat);
		queue_check("unmapped latency", 1, lat);
		bus_access(1, REGION_NONE, 9, 0, 4'hf, '0, rdat, lat);
		queue_check("unmapped debug read", expected_read(REGION_NONE, 9), rdat);
		// same low index bits as an sram word that it must not reach
		bus_access(0, REGION_NONE, idx[0], 1, 4'hf, 32'hdead_beef, rdat, lat);
		bus_access(0, soc_pkg::REGION_SRAM, idx[0], 0, 4'hf, '0, rdat, lat);
		queue_check("sram after unmapped write",
			expected_read(soc_pkg::REGION_SRAM, idx[0]), rdat);
		report_test("unmapped");

		cmp = $urandom_range(3, 12);
		bus_access(0, soc_pkg::REGION_TIMER, soc_pkg::TIMER_CMP, 1, 4'hf, cmp, rdat, lat);
		bus_access(0, soc_pkg::REGION_TIMER, soc_pkg::TIMER_CTL, 1, 4'hf, 32'd1, rdat, lat);
		bus_access(1, soc_pkg::REGION_TIMER, soc_pkg::TIMER_CMP, 0, 4'hf, '0, rdat, lat);
		queue_check("timer compare",
			expected_read(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CMP), rdat);
		for (int i = 0; i < 6; i++) begin
			bus_access(0, soc_pkg::REGION_TIMER, soc_pkg::TIMER_CNT, 0, 4'hf, '0, rdat, lat);
			queue_check("timer count bound", 32'd1, {31'b0, rdat <= ref_cmp});
		end
		seen  = 1'b0;
		polls = 0;
		while (!seen && polls < POLL_LIMIT) begin
			bus_access(0, soc_pkg::REGION_IRQ, soc_pkg::IRQ_PEND, 0, 4'hf, '0, rdat, lat);
			seen = rdat[0];
			polls++;
		end
		if (!seen) begin
			errors++;
			$display("timeout: timer interrupt never became pending");
		end
		ref_pend[0] = 1'b1;
		bus_access(0, soc_pkg::REGION_TIMER, soc_pkg::TIMER_CTL, 1, 4'hf, 32'd0, rdat, lat);
		queue_check("irq low with mask clear", 0, irq);
		report_test("timer");

		@(posedge clk);
		ext_irq <= 2'b11;
		@(posedge clk);
		ext_irq <= 2'b00;
		ref_pend[2:1] = 2'b11;
		bus_access(1, soc_pkg::REGION_IRQ, soc_pkg::IRQ_PEND, 0, 4'hf, '0, rdat, lat);
		queue_check("pending after pulse",
			expected_read(soc_pkg::REGION_IRQ, soc_pkg::IRQ_PEND), rdat);
		queue_check("irq masked", 0, irq);
		bus_access(0, soc_pkg::REGION_IRQ, soc_pkg::IRQ_ENA, 1, 4'hf, 32'h7, rdat, lat);
		wait_irq_level(1'b1, "irq_o never went high after the mask was set");
		bus_access(0, soc_pkg::REGION_IRQ, soc_pkg::IRQ_PEND, 1, 4'hf, 32'h7, rdat, lat);
		wait_irq_level(1'b0, "irq_o never went low after pending was cleared");
		bus_access(1, soc_pkg::REGION_IRQ, soc_pkg::IRQ_PEND, 0, 4'hf, '0, rdat, lat);
		queue_check("pending after clear",
			expected_read(soc_pkg::REGION_IRQ, soc_pkg::IRQ_PEND), rdat);
		bus_access(1, soc_pkg::REGION_IRQ, soc_pkg::IRQ_ENA, 0, 4'hf, '0, rdat, lat);
		queue_check("mask read", expected_read(soc_pkg::REGION_IRQ, soc_pkg::IRQ_ENA), rdat);
		report_test("interrupt controller");

		assert_fails = DUT.u_arbiter.u_checker.fails;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== tb/tb_clock.sv ====
/*
 * testbench clock and reset
 * 10 ns clock, reset held high for the first 8 cycles
 */

`timescale 1ns/1ps

module tb_clock (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	initial begin
		reset_o <= 1'b1;
		repeat (8) @(posedge clk_o);
		reset_o <= 1'b0;
	end

endmodule
